//--- include/head_array_defs.svh
// head array sizes and widths
`ifndef HEAD_ARRAY_DEFS_SVH
`define HEAD_ARRAY_DEFS_SVH

////////////////////////////////////////
// head organisation
////////////////////////////////////////

`define HA_HEAD_NUM      4
`define HA_HEAD_W        2

////////////////////////////////////////
// host port
////////////////////////////////////////

`define HA_DATA_W        16
// region bit, head field, offset
`define HA_ADDR_W        9
`define HA_OFFSET_W      6

////////////////////////////////////////
// per head memories
////////////////////////////////////////

// kv region is split by user, then by entry
`define HA_USER_NUM      4
`define HA_USER_W        2
`define HA_KV_ENTRIES    16
`define HA_KV_ENTRY_W    4
`define HA_CORE_DEPTH    64

`endif

//--- rtl/head_array_pkg.sv
// head array shared types
`include "head_array_defs.svh"

package head_array_pkg;

    // top bit of the host address
    typedef enum logic [0:0] {
        REGION_CORE = 1'b0,
        REGION_KV   = 1'b1
    } region_e;

    // address as seen inside one head
    // in the kv region the offset is {user, entry}
    typedef struct packed {
        region_e                  region;
        logic [`HA_OFFSET_W-1:0]  offset;
    } head_addr_t;

    // kv clean sequencer
    typedef enum logic [1:0] {
        CLEAN_IDLE = 2'd0,
        CLEAN_RUN  = 2'd1,
        CLEAN_DONE = 2'd2
    } clean_state_e;

endpackage

//--- rtl/head_access_decode.sv
// host request decode
`timescale 1ns/1ns
`include "head_array_defs.svh"

module head_access_decode (
    input  logic                                        clk,
    input  logic                                        rst_n,

    input  logic [`HA_ADDR_W-1:0]                       mem_addr,
    input  logic [`HA_DATA_W-1:0]                       mem_wdata,
    input  logic                                        mem_wen,
    input  logic                                        mem_ren,

    output head_array_pkg::head_addr_t [`HA_HEAD_NUM-1:0] head_addr,
    output logic [`HA_HEAD_NUM-1:0][`HA_DATA_W-1:0]     head_wdata,
    output logic [`HA_HEAD_NUM-1:0]                     head_wen,
    output logic [`HA_HEAD_NUM-1:0]                     head_ren,

    input  logic                                        clean_kv_cache,
    input  logic [`HA_USER_W-1:0]                       clean_kv_cache_user_id,
    output logic                                        clean_start,
    output logic [`HA_USER_W-1:0]                       clean_user
);

    import head_array_pkg::*;

    logic [`HA_HEAD_W-1:0]   head_sel;
    logic [`HA_HEAD_NUM-1:0] head_onehot;
    head_addr_t              in_addr;
    logic                    rd_only;

    ////////////////////////////////////////
    // address split
    ////////////////////////////////////////

    always_comb begin
        head_sel       = mem_addr[`HA_ADDR_W-2 -: `HA_HEAD_W];
        head_onehot    = `HA_HEAD_NUM'(1) << head_sel;
        in_addr.region = region_e'(mem_addr[`HA_ADDR_W-1]);
        in_addr.offset = mem_addr[`HA_OFFSET_W-1:0];
        // a write wins over a read in the same cycle
        rd_only        = mem_ren & ~mem_wen;
    end

    ////////////////////////////////////////
    // request register
    ////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            head_wen    <= '0;
            head_ren    <= '0;
            clean_start <= 1'b0;
        end else begin
            head_wen    <= mem_wen ? head_onehot : '0;
            head_ren    <= rd_only ? head_onehot : '0;
            clean_start <= clean_kv_cache;
        end
    end

    // only the addressed head sees its address and data move
    always_ff @(posedge clk) begin
        for (int i = 0; i < `HA_HEAD_NUM; i++) begin
            if (head_onehot[i] && (mem_wen || mem_ren)) begin
                head_addr[i]  <= in_addr;
                head_wdata[i] <= mem_wdata;
            end
        end
        // user id held until the next clean, heads read it while running
        if (clean_kv_cache) begin
            clean_user <= clean_kv_cache_user_id;
        end
    end

endmodule

//--- rtl/head_bank.sv
// single head memory bank
`timescale 1ns/1ns
`include "head_array_defs.svh"

module head_bank (
    input  logic                        clk,
    input  logic                        rst_n,

    input  head_array_pkg::head_addr_t  head_addr,
    input  logic [`HA_DATA_W-1:0]       head_wdata,
    input  logic                        head_wen,
    input  logic                        head_ren,
    output logic [`HA_DATA_W-1:0]       head_rdata,
    output logic                        head_rvld,

    input  logic                        clean_start,
    input  logic [`HA_USER_W-1:0]       clean_user,
    output logic                        clean_done
);

    import head_array_pkg::*;

    localparam int KV_DEPTH = `HA_USER_NUM * `HA_KV_ENTRIES;

    logic [`HA_DATA_W-1:0] core_mem [`HA_CORE_DEPTH];
    logic [`HA_DATA_W-1:0] kv_mem [KV_DEPTH];

    // fill per user, one above the highest entry written
    logic [`HA_USER_NUM-1:0][`HA_KV_ENTRY_W:0] kv_fill;

    clean_state_e              clean_state;
    logic [`HA_KV_ENTRY_W:0]   clean_ptr;
    logic                      clean_wr;
    logic [`HA_OFFSET_W-1:0]   clean_idx;

    logic                      is_kv;
    logic [`HA_USER_W-1:0]     kv_user;
    logic [`HA_KV_ENTRY_W-1:0] kv_entry;

    logic [`HA_DATA_W-1:0]     rd_word;
    logic                      rd_pend;

    always_comb begin
        is_kv     = (head_addr.region == REGION_KV);
        kv_user   = head_addr.offset[`HA_OFFSET_W-1 -: `HA_USER_W];
        kv_entry  = head_addr.offset[`HA_KV_ENTRY_W-1:0];
        clean_wr  = (clean_state == CLEAN_RUN) && (clean_ptr < kv_fill[clean_user]);
        clean_idx = {clean_user, clean_ptr[`HA_KV_ENTRY_W-1:0]};
    end

    assign clean_done = (clean_state == CLEAN_DONE);

    ////////////////////////////////////////
    // memory arrays and read pipe
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (head_wen) begin
            if (is_kv) begin
                kv_mem[head_addr.offset] <= head_wdata;
            end else begin
                core_mem[head_addr.offset] <= head_wdata;
            end
        end
        // host never touches the user under clean, so no port clash
        if (clean_wr) begin
            kv_mem[clean_idx] <= '0;
        end
        if (head_ren) begin
            rd_word <= is_kv ? kv_mem[head_addr.offset] : core_mem[head_addr.offset];
        end
        // second stage, output flop
        if (rd_pend) begin
            head_rdata <= rd_word;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_pend   <= 1'b0;
            head_rvld <= 1'b0;
        end else begin
            rd_pend   <= head_ren;
            head_rvld <= rd_pend;
        end
    end

    ////////////////////////////////////////
    // fill tracking and clean FSM
    ////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            kv_fill     <= '0;
            clean_state <= CLEAN_IDLE;
            clean_ptr   <= '0;
        end else begin
            if (head_wen && is_kv && ({1'b0, kv_entry} >= kv_fill[kv_user])) begin
                kv_fill[kv_user] <= {1'b0, kv_entry} + 1'b1;
            end

            case (clean_state)
                CLEAN_IDLE: begin
                    if (clean_start) begin
                        clean_state <= CLEAN_RUN;
                        clean_ptr   <= '0;
                    end
                end
                CLEAN_RUN: begin
                    // one zero write per cycle up to the fill
                    if (clean_wr) begin
                        clean_ptr <= clean_ptr + 1'b1;
                    end else begin
                        clean_state         <= CLEAN_DONE;
                        kv_fill[clean_user] <= '0;
                    end
                end
                CLEAN_DONE: begin
                    clean_state <= CLEAN_IDLE;
                end
                default: begin
                    clean_state <= CLEAN_IDLE;
                end
            endcase
        end
    end

endmodule

//--- rtl/read_merge.sv
// head read data merge
`timescale 1ns/1ns
`include "head_array_defs.svh"

module read_merge (
    input  logic                                    clk,
    input  logic                                    rst_n,

    input  logic [`HA_HEAD_NUM-1:0][`HA_DATA_W-1:0] head_rdata,
    input  logic [`HA_HEAD_NUM-1:0]                 head_rvld,

    output logic [`HA_DATA_W-1:0]                   mem_rdata,
    output logic                                    mem_rvld
);

    logic [`HA_DATA_W-1:0] merge_data;
    logic                  merge_vld;

    // at most one head valid per cycle, so an AND-OR mux is enough
    always_comb begin
        merge_vld  = |head_rvld;
        merge_data = '0;
        for (int i = 0; i < `HA_HEAD_NUM; i++) begin
            merge_data = merge_data | (head_rdata[i] & {`HA_DATA_W{head_rvld[i]}});
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mem_rvld <= 1'b0;
        end else begin
            mem_rvld <= merge_vld;
        end
    end

    // zero when idle
    always_ff @(posedge clk) begin
        mem_rdata <= merge_data;
    end

endmodule

//--- rtl/finish_sync.sv
// clean finish aggregation
`timescale 1ns/1ns
`include "head_array_defs.svh"

module finish_sync (
    input  logic                    clk,
    input  logic                    rst_n,

    input  logic [`HA_HEAD_NUM-1:0] clean_done,
    output logic                    finish
);

    // heads end at different times, remember who is through
    logic [`HA_HEAD_NUM-1:0] done_flag;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            done_flag <= '0;
        end else if (finish) begin
            done_flag <= '0;
        end else begin
            done_flag <= done_flag | clean_done;
        end
    end

    ////////////////////////////////////////
    // single cycle finish
    ////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            finish <= 1'b0;
        end else if (finish) begin
            finish <= 1'b0;
        end else begin
            finish <= &done_flag;
        end
    end

endmodule

//--- rtl/head_array_top.sv
// four head memory array
`timescale 1ns/1ns
`include "head_array_defs.svh"

module head_array_top (
    input  logic                    clk,
    input  logic                    rst_n,

    input  logic                    clean_kv_cache,
    input  logic [`HA_USER_W-1:0]   clean_kv_cache_user_id,

    input  logic [`HA_ADDR_W-1:0]   mem_addr,
    input  logic [`HA_DATA_W-1:0]   mem_wdata,
    input  logic                    mem_wen,
    input  logic                    mem_ren,
    output logic [`HA_DATA_W-1:0]   mem_rdata,
    output logic                    mem_rvld,

    output logic                    finish
);

    import head_array_pkg::*;

    head_addr_t [`HA_HEAD_NUM-1:0]                head_addr;
    logic [`HA_HEAD_NUM-1:0][`HA_DATA_W-1:0]      head_wdata;
    logic [`HA_HEAD_NUM-1:0]                      head_wen;
    logic [`HA_HEAD_NUM-1:0]                      head_ren;
    logic [`HA_HEAD_NUM-1:0][`HA_DATA_W-1:0]      head_rdata;
    logic [`HA_HEAD_NUM-1:0]                      head_rvld;

    logic                                         clean_start;
    logic [`HA_USER_W-1:0]                        clean_user;
    logic [`HA_HEAD_NUM-1:0]                      clean_done;

    ////////////////////////////////////////
    // input side
    ////////////////////////////////////////

    head_access_decode i_decode (
        .clk                    (clk),
        .rst_n                  (rst_n),
        .mem_addr               (mem_addr),
        .mem_wdata              (mem_wdata),
        .mem_wen                (mem_wen),
        .mem_ren                (mem_ren),
        .head_addr              (head_addr),
        .head_wdata             (head_wdata),
        .head_wen               (head_wen),
        .head_ren               (head_ren),
        .clean_kv_cache         (clean_kv_cache),
        .clean_kv_cache_user_id (clean_kv_cache_user_id),
        .clean_start            (clean_start),
        .clean_user             (clean_user)
    );

    ////////////////////////////////////////
    // heads
    ////////////////////////////////////////

    for (genvar h = 0; h < `HA_HEAD_NUM; h++) begin : gen_head
        head_bank i_bank (
            .clk         (clk),
            .rst_n       (rst_n),
            .head_addr   (head_addr[h]),
            .head_wdata  (head_wdata[h]),
            .head_wen    (head_wen[h]),
            .head_ren    (head_ren[h]),
            .head_rdata  (head_rdata[h]),
            .head_rvld   (head_rvld[h]),
            .clean_start (clean_start),
            .clean_user  (clean_user),
            .clean_done  (clean_done[h])
        );
    end

    ////////////////////////////////////////
    // output side
    ////////////////////////////////////////

    read_merge i_merge (
        .clk        (clk),
        .rst_n      (rst_n),
        .head_rdata (head_rdata),
        .head_rvld  (head_rvld),
        .mem_rdata  (mem_rdata),
        .mem_rvld   (mem_rvld)
    );

    finish_sync i_finish (
        .clk        (clk),
        .rst_n      (rst_n),
        .clean_done (clean_done),
        .finish     (finish)
    );

endmodule

//--- tb/tb_clk_gen.sv
// testbench clock and reset
`timescale 1ns/1ns

module tb_clk_gen (
    output logic clk,
    output logic rst_n
);

    // 20 ns period
    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // reset held for ten clock cycles
    initial begin
        rst_n = 1'b0;
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
    end

endmodule

//--- tb/head_array_assert.sv
// head array protocol checks
`timescale 1ns/1ns
`include "head_array_defs.svh"

module head_array_assert (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    mem_wen,
    input  logic                    mem_ren,
    input  logic                    mem_rvld,
    input  logic                    finish,
    input  logic [`HA_HEAD_NUM-1:0] clean_done
);

    // failed assertions so far
    int fail_cnt = 0;

    // finish is a single cycle pulse
    finish_single: assert property (
        @(posedge clk) disable iff (!rst_n)
        finish |=> !finish
    ) else begin
        fail_cnt++;
        $error("finish stayed high for two cycles");
    end

    // read sampled at edge n raises rvld at edge n+3, seen sampled at n+4
    // write wins over read
    rvld_latency: assert property (
        @(posedge clk) disable iff (!rst_n)
        mem_rvld == $past(mem_ren && !mem_wen, 4)
    ) else begin
        fail_cnt++;
        $error("mem_rvld does not follow a read three cycles earlier");
    end

    // every head pulses its done for one cycle only
    done_single: assert property (
        @(posedge clk) disable iff (!rst_n)
        (clean_done & $past(clean_done)) == '0
    ) else begin
        fail_cnt++;
        $error("clean_done of a head high two cycles in a row");
    end

endmodule

//--- tb/tb_head_array.sv
// head array testbench
`timescale 1ns/1ns
`include "head_array_defs.svh"

module tb_head_array;

    logic                   clk;
    logic                   rst_n;
    logic                   clean_kv_cache;
    logic [`HA_USER_W-1:0]  clean_kv_cache_user_id;
    logic [`HA_ADDR_W-1:0]  mem_addr;
    logic [`HA_DATA_W-1:0]  mem_wdata;
    logic                   mem_wen;
    logic                   mem_ren;
    logic [`HA_DATA_W-1:0]  mem_rdata;
    logic                   mem_rvld;
    logic                   finish;

    logic [`HA_DATA_W-1:0]  shadow [1 << `HA_ADDR_W];
    logic [`HA_DATA_W-1:0]  exp_q [$];
    int                     iss_q [$];
    int                     seed = 32'h587a;
    int                     cyc = 0;
    int                     fin_cnt = 0;
    int                     err_cnt = 0;
    int                     chk_cnt = 0;
    int                     test_base = 0;

    tb_clk_gen i_clk_gen (.clk(clk), .rst_n(rst_n));

    head_array_top i_dut (
        .clk                    (clk),
        .rst_n                  (rst_n),
        .clean_kv_cache         (clean_kv_cache),
        .clean_kv_cache_user_id (clean_kv_cache_user_id),
        .mem_addr               (mem_addr),
        .mem_wdata              (mem_wdata),
        .mem_wen                (mem_wen),
        .mem_ren                (mem_ren),
        .mem_rdata              (mem_rdata),
        .mem_rvld               (mem_rvld),
        .finish                 (finish)
    );

    bind head_array_top head_array_assert i_assert (
        .clk        (clk),
        .rst_n      (rst_n),
        .mem_wen    (mem_wen),
        .mem_ren    (mem_ren),
        .mem_rvld   (mem_rvld),
        .finish     (finish),
        .clean_done (clean_done)
    );

    ////////////////////////////////////////
    // reference model and helpers
    ////////////////////////////////////////

    function automatic logic [`HA_DATA_W-1:0] ref_word(input logic [`HA_ADDR_W-1:0] addr);
        ref_word = shadow[addr];
    endfunction

    // a clean empties all entries of the user in every head
    function automatic void clear_user_ref(input int user);
        for (int h = 0; h < `HA_HEAD_NUM; h++) begin
            for (int e = 0; e < `HA_KV_ENTRIES; e++) begin
                shadow[kv_addr(h, user, e)] = '0;
            end
        end
    endfunction

    function automatic logic [`HA_ADDR_W-1:0] kv_addr(input int h, input int u, input int e);
        kv_addr = {1'b1, 2'(h), 2'(u), 4'(e)};
    endfunction

    function automatic logic [`HA_DATA_W-1:0] fill_word(input logic [`HA_ADDR_W-1:0] a);
        fill_word = {~a[6:0], a};
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        chk_cnt++;
        if (got !== exp) begin
            $display("mismatch %s: got %h, expected %h", name, got, exp);
            err_cnt++;
        end
    endtask

    task automatic write_word(input logic [`HA_ADDR_W-1:0] addr,
                              input logic [`HA_DATA_W-1:0] data);
        @(negedge clk);
        mem_addr  = addr;
        mem_wdata = data;
        mem_wen   = 1'b1;
        mem_ren   = 1'b0;
        shadow[addr] = data;
    endtask

    // ren is sampled on the next rising edge
    task automatic read_word(input logic [`HA_ADDR_W-1:0] addr);
        @(negedge clk);
        mem_addr = addr;
        mem_wen  = 1'b0;
        mem_ren  = 1'b1;
        exp_q.push_back(ref_word(addr));
        iss_q.push_back(cyc + 1);
    endtask

    task automatic bus_idle();
        @(negedge clk);
        mem_wen        = 1'b0;
        mem_ren        = 1'b0;
        clean_kv_cache = 1'b0;
    endtask

    task automatic drain_reads();
        int n;
        n = 0;
        while (exp_q.size() != 0 && n < 100) begin
            @(negedge clk);
            n++;
        end
        if (exp_q.size() != 0) begin
            $display("timeout: %0d reads never returned data", exp_q.size());
            err_cnt++;
            exp_q.delete();
            iss_q.delete();
        end
        @(negedge clk);
    endtask

    task automatic run_clean(input int user);
        int base;
        int n;
        bus_idle();
        clean_kv_cache         = 1'b1;
        clean_kv_cache_user_id = 2'(user);
        base = fin_cnt;
        @(negedge clk);
        clean_kv_cache = 1'b0;
        clear_user_ref(user);
        n = 0;
        while (fin_cnt == base && n < 200) begin
            @(negedge clk);
            n++;
        end
        if (fin_cnt == base) begin
            $display("timeout: no finish pulse after clean of user %0d", user);
            err_cnt++;
        end
        // watch for a second pulse
        repeat (20) @(negedge clk);
        check_value("finish_pulses", fin_cnt - base, 1);
    endtask

    task automatic verify_all();
        for (int a = 0; a < (1 << `HA_ADDR_W); a++) begin
            read_word(9'(a));
        end
        bus_idle();
        drain_reads();
    endtask

    task automatic close_test(input string name);
        $display("test %s done with %0d errors", name, err_cnt - test_base);
        test_base = err_cnt;
    endtask

    always @(posedge clk) begin
        cyc <= cyc + 1;
        if (finish) begin
            fin_cnt <= fin_cnt + 1;
        end
    end

    ////////////////////////////////////////
    // read compare
    ////////////////////////////////////////

    always @(negedge clk) begin
        if (rst_n && mem_rvld) begin
            if (exp_q.size() == 0) begin
                $display("read data valid with no read outstanding");
                err_cnt++;
            end else begin
                check_value("mem_rdata", 32'(mem_rdata), 32'(exp_q.pop_front()));
                check_value("read_latency", cyc - iss_q.pop_front(), 3);
            end
        end
    end

    ////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////

    initial begin
        logic [`HA_ADDR_W-1:0] addr_list [40];
        int n;
        clean_kv_cache         = 1'b0;
        clean_kv_cache_user_id = '0;
        mem_addr               = '0;
        mem_wdata              = '0;
        mem_wen                = 1'b0;
        mem_ren                = 1'b0;
        n = 0;
        while (!rst_n && n < 50) begin
            @(negedge clk);
            n++;
        end
        if (!rst_n) begin
            $display("timeout: reset never released");
            err_cnt++;
        end

        for (int i = 0; i < 20; i++) begin
            @(negedge clk);
            check_value("mem_rvld", 32'(mem_rvld), 0);
            check_value("finish", 32'(finish), 0);
        end
        close_test("reset_idle");

        // known contents everywhere, kv fills end up full
        for (int a = 0; a < (1 << `HA_ADDR_W); a++) begin
            write_word(9'(a), fill_word(9'(a)));
        end

        for (int i = 0; i < 40; i++) begin
            addr_list[i] = {1'b0, 8'($random(seed))};
            write_word(addr_list[i], 16'($random(seed)));
        end
        for (int i = 0; i < 40; i++) begin
            read_word(addr_list[i]);
        end
        bus_idle();
        drain_reads();
        close_test("core_write_read");

        // same entries across heads and users
        for (int h = 0; h < `HA_HEAD_NUM; h++) begin
            for (int u = 0; u < `HA_USER_NUM; u++) begin
                write_word(kv_addr(h, u, 5), 16'($random(seed)));
                write_word(kv_addr(h, u, 11), 16'($random(seed)));
            end
        end
        for (int h = 0; h < `HA_HEAD_NUM; h++) begin
            for (int u = 0; u < `HA_USER_NUM; u++) begin
                read_word(kv_addr(h, u, 5));
                read_word(kv_addr(h, u, 11));
            end
        end
        bus_idle();
        drain_reads();
        close_test("kv_write_read");

        // empty user 2, then refill with fills 2, 5, 8 and 11
        run_clean(2);
        for (int h = 0; h < `HA_HEAD_NUM; h++) begin
            for (int e = 0; e < 3 * h + 2; e++) begin
                write_word(kv_addr(h, 2, e), 16'($random(seed)));
            end
        end
        run_clean(2);
        verify_all();
        close_test("kv_clean");

        // nothing written since the last clean
        run_clean(2);
        for (int h = 0; h < `HA_HEAD_NUM; h++) begin
            write_word(kv_addr(h, 2, h + 3), 16'($random(seed)));
        end
        for (int h = 0; h < `HA_HEAD_NUM; h++) begin
            read_word(kv_addr(h, 2, h + 3));
            read_word(kv_addr(h, 2, 0));
        end
        bus_idle();
        drain_reads();
        close_test("empty_clean");

        if (i_dut.i_assert.fail_cnt != 0) begin
            $display("protocol assertions failed %0d times", i_dut.i_assert.fail_cnt);
            err_cnt += i_dut.i_assert.fail_cnt;
        end

        $display("checks run: %0d, errors: %0d", chk_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

//--- flist.f
+incdir+include
rtl/head_array_pkg.sv
rtl/head_access_decode.sv
rtl/head_bank.sv
rtl/read_merge.sv
rtl/finish_sync.sv
rtl/head_array_top.sv
tb/tb_clk_gen.sv
tb/head_array_assert.sv
tb/tb_head_array.sv

//--- run.sh
#!/bin/sh
# build and run the head array testbench with Verilator

verilator --binary --timing --assert -f flist.f --top-module tb_head_array \
    -o sim_head_array > build.log 2>&1 \
    || { cat build.log; echo "build failed"; exit 1; }

./obj_dir/sim_head_array > sim.log 2>&1 \
    || { cat sim.log; echo "simulation stopped with an error"; exit 1; }

cat sim.log
grep -q "Errors found" sim.log && exit 1 || exit 0
